// File: rtl/instrClassifier.sv
module instrClassifier import uopPkg::*; (
	input logic clk,
	input logic reset,
	input logic inValid,
	input instrWord_t inInstr,
	output logic inReady,
	input logic seqDone,
	output instrWord_t heldInstr,
	output instrClass_t heldClass,
	output logic heldValid
);

	instrClass_t decClass;	// Class of the word on inInstr
	logic accept;	// Input handshake completes
	logic isBx;	// BX/BLX share the shift-by-register bit pattern

	assign inReady = !heldValid;	// One instruction in flight
	assign accept = inValid && inReady;

	assign isBx = (inInstr[27:6] == {8'b0001_0010, 12'hFFF, 2'b00});

	always_comb begin
		if (inInstr[27:24] == 4'b1011)
			decClass = clsBranchLink;	// B with L set
		else if (inInstr[27:25] == 3'b100)
			decClass = inInstr[20] ? clsLoadMulti : clsStoreMulti;	// L bit picks LDM
		else if (inInstr[27:25] == 3'b000 && !inInstr[7] && inInstr[4] && !isBx)
			decClass = clsRegShiftReg;	// Shift amount from Rs
		else
			decClass = clsPlain;
	end

	always_ff @(posedge clk) begin
		if (reset)
			heldValid <= 1'b0;
		else if (accept)
			heldValid <= 1'b1;
		else if (seqDone)
			heldValid <= 1'b0;	// Last micro-op leaves
	end

	// Payload is only meaningful while heldValid
	always_ff @(posedge clk) begin
		if (accept) begin
			heldInstr <= inInstr;
			heldClass <= decClass;
		end
	end

	// Done must belong to the held instruction and never meet a new acceptance
	aDoneWhileHeld: assert property (@(posedge clk) disable iff (reset)
		seqDone |-> heldValid);

endmodule

// File: rtl/multiRegIf.sv
interface multiRegIf import uopPkg::*; ();

	logic load;	// Take a fresh list from regList
	logic advance;	// Drop the lowest set bit
	regList_t regList;	// List field of the held instruction
	regNum_t nextReg;	// Lowest register still to transfer
	regCount_t remaining;	// Registers still to transfer, this one included
	logic [11:0] startImm;	// Offset of the first transfer from Rn
	logic addUp;	// First transfer adds startImm to Rn

	modport walker (
		input load, advance, regList,
		output nextReg, remaining, startImm, addUp
	);

	modport seq (
		output load, advance, regList,
		input nextReg, remaining, startImm, addUp
	);

endinterface

// File: rtl/regListWalker.sv
module regListWalker import uopPkg::*; (
	input logic clk,
	input logic reset,
	multiRegIf.walker mr,
	input logic pBit,	// Bit 24, before/after
	input logic uBit	// Bit 23, increment/decrement
);

	regList_t listQ;	// Registers not yet transferred
	regList_t curList;	// List the outputs look at this cycle
	logic [11:0] fourCount;	// Count times four, in offset width

	// On load the fresh list is visible at once, so the first transfer needs no extra cycle
	assign curList = mr.load ? mr.regList : listQ;

	always_ff @(posedge clk) begin
		if (reset)
			listQ <= '0;
		else if (mr.load || mr.advance)
			listQ <= mr.advance ? (curList & (curList - 1'b1)) : curList;	// Clear lowest set bit
	end

	// Lowest set register goes first
	always_comb begin
		mr.nextReg = '0;
		for (int i = 15; i >= 0; i--) begin
			if (curList[i])
				mr.nextReg = regNum_t'(i);
		end
	end

	assign mr.remaining = regCount_t'($countones(curList));
	assign fourCount = 12'({mr.remaining, 2'b00});

	// Start address relative to Rn; only used with the full list present
	always_comb begin
		case ({pBit, uBit})
			2'b00: mr.startImm = fourCount - 12'd4;	// DA, Rn - 4*n + 4
			2'b01: mr.startImm = 12'd0;	// IA, Rn
			2'b10: mr.startImm = fourCount;	// DB, Rn - 4*n
			default: mr.startImm = 12'd4;	// IB, Rn + 4
		endcase
	end

	assign mr.addUp = uBit;	// Decrementing modes subtract the start offset

	// The sequencer must stop stepping once the list is used up
	aNoAdvanceEmpty: assert property (@(posedge clk) disable iff (reset)
		mr.advance |-> mr.remaining != '0);

endmodule

// File: rtl/uopExpander.sv
module uopExpander import uopPkg::*; (
	input logic clk,
	input logic reset,
	input logic inValid,
	input instrWord_t inInstr,
	output logic inReady,
	output logic uopValid,
	output instrWord_t uopWord,
	output rzSel_t uopRz,
	output logic uopForward,
	input logic uopReady
);

	instrWord_t heldInstr;	// Instruction being expanded
	instrClass_t heldClass;
	logic heldValid;
	logic seqDone;	// Last micro-op transfers

	multiRegIf mr ();	// Walker to sequencer

	instrClassifier classifier (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inInstr(inInstr),
		.inReady(inReady),
		.seqDone(seqDone),
		.heldInstr(heldInstr),
		.heldClass(heldClass),
		.heldValid(heldValid)
	);

	regListWalker walker (
		.clk(clk),
		.reset(reset),
		.mr(mr.walker),
		.pBit(heldInstr[24]),	// P, before/after
		.uBit(heldInstr[23])	// U, up/down
	);

	uopSequencer sequencer (
		.clk(clk),
		.reset(reset),
		.heldInstr(heldInstr),
		.heldClass(heldClass),
		.heldValid(heldValid),
		.seqDone(seqDone),
		.mr(mr.seq),
		.uopValid(uopValid),
		.uopWord(uopWord),
		.uopRz(uopRz),
		.uopForward(uopForward),
		.uopReady(uopReady)
	);

endmodule

// File: rtl/uopPkg.sv
package uopPkg;

	typedef logic [31:0] instrWord_t;	// Architectural instruction or micro-op word
	typedef logic [15:0] regList_t;	// One bit per register, R0 in bit 0
	typedef logic [3:0] regNum_t;	// Register number R0..R15
	typedef logic [4:0] regCount_t;	// Register count, 0 to 16

	// Instruction class, decoded once when the instruction is accepted
	typedef enum logic [2:0] {
		clsPlain,	// Passes through as one micro-op
		clsBranchLink,	// BL, link write then branch
		clsRegShiftReg,	// Shift by register, shift into Rz then operate
		clsLoadMulti,	// LDM
		clsStoreMulti	// STM
	} instrClass_t;

	// Expansion FSM states
	typedef enum logic [2:0] {
		stIdle,	// No sequence running, entry op comes from heldClass
		stFirst,	// First op of a one- or two-op sequence
		stSecond,	// Second op of BL or shift-by-register
		stMultiFirst,	// First transfer of LDM/STM, base Rn
		stMultiNext,	// Later transfers, base Rz
		stMultiWriteback	// Base register update
	} seqState_t;

	// Register file steering toward the scratch register
	typedef struct packed {
		logic initMux;	// RA1 initial mux picks Rz
		logic wa3Rz;	// Write port targets Rz
		logic ra2Rz;	// Read port 2 reads Rz
		logic ra1Rz;	// Read port 1 reads Rz
	} rzSel_t;

	localparam regNum_t regRz = 4'd15;	// With an rzSel_t bit set, code 15 means Rz
	localparam regNum_t regLink = 4'd14;	// LR

	// Data-processing opcodes, bits 24:21
	typedef enum logic [3:0] {
		opcodeSub = 4'b0010,
		opcodeAdd = 4'b0100,
		opcodeMov = 4'b1101
	} dpOpcode_t;

	// Condition field, bits 31:28
	function automatic logic [3:0] condField(input instrWord_t word);
		return word[31:28];
	endfunction

endpackage

// File: rtl/uopSequencer.sv
module uopSequencer import uopPkg::*; (
	input logic clk,
	input logic reset,
	input instrWord_t heldInstr,
	input instrClass_t heldClass,
	input logic heldValid,
	output logic seqDone,
	multiRegIf.seq mr,
	output logic uopValid,
	output instrWord_t uopWord,
	output rzSel_t uopRz,
	output logic uopForward,
	input logic uopReady
);

	seqState_t state, nextState;	// Registered state and its successor
	seqState_t curState;	// State the outputs are built for
	logic xfer;	// Micro-op transfers this cycle
	logic lastOp;	// Current micro-op ends the sequence
	logic isLoad, writeBack;	// L and W bits of LDM/STM
	logic listEmpty, lastReg;	// Walker list empty, or on its final register
	regCount_t totalCount;	// Full list size, for the writeback amount
	logic [3:0] cond;
	dpOpcode_t wbOp;

	assign uopValid = heldValid;	// Every held instruction yields at least one op
	assign xfer = uopValid && uopReady;
	assign seqDone = xfer && lastOp;

	assign cond = condField(heldInstr);
	assign isLoad = heldInstr[20];
	assign writeBack = heldInstr[21];
	assign totalCount = regCount_t'($countones(heldInstr[15:0]));
	assign wbOp = heldInstr[23] ? opcodeAdd : opcodeSub;	// Base moves up or down
	assign listEmpty = (mr.remaining == '0);
	assign lastReg = (mr.remaining == regCount_t'(1));

	assign mr.regList = heldInstr[15:0];

	// Idle stands in for the entry state, so the first op shows right after acceptance
	always_comb begin
		if (state != stIdle)
			curState = state;
		else if (heldClass == clsLoadMulti || heldClass == clsStoreMulti)
			curState = stMultiFirst;
		else
			curState = stFirst;
	end

	// Walker steps only when a transfer op actually goes out
	assign mr.advance = xfer && ((curState == stMultiFirst && !listEmpty)
		|| curState == stMultiNext);

	always_comb begin
		uopWord = heldInstr;
		uopRz = '0;
		uopForward = 1'b0;
		lastOp = 1'b1;
		nextState = stIdle;
		mr.load = 1'b0;
		case (curState)
			stFirst: begin
				if (heldClass == clsBranchLink) begin
					// SUB LR, PC, #4, no flags
					uopWord = {cond, 3'b001, opcodeSub, 1'b0, 4'hF, regLink, 12'h004};
					lastOp = 1'b0;
					nextState = stSecond;
				end else if (heldClass == clsRegShiftReg) begin
					// MOV Rz, Rm shifted by Rs
					uopWord = {heldInstr[31:25], opcodeMov, 1'b0, 4'h0, regRz, heldInstr[11:0]};
					uopRz.initMux = 1'b1;
					uopRz.wa3Rz = 1'b1;
					lastOp = 1'b0;
					nextState = stSecond;
				end
			end
			stSecond: begin
				if (heldClass == clsBranchLink) begin
					uopWord = {heldInstr[31:25], 1'b0, heldInstr[23:0]};	// Plain B
				end else begin
					uopWord = {heldInstr[31:12], 8'h00, regRz};	// Operand 2 is Rz, no shift
					uopRz.ra2Rz = 1'b1;
				end
			end
			stMultiFirst: begin
				mr.load = 1'b1;
				if (listEmpty) begin
					uopWord = {cond, 3'b001, opcodeAdd, 1'b0, 20'h00000};	// ADD R0, R0, #0
				end else begin
					// Pre-indexed word transfer from Rn, no writeback
					uopWord = {cond, 3'b010, 1'b1, mr.addUp, 1'b0, 1'b0, isLoad,
						heldInstr[19:16], mr.nextReg, mr.startImm};
					uopRz.ra1Rz = isLoad;
					lastOp = lastReg && !writeBack;
					nextState = lastReg ? (writeBack ? stMultiWriteback : stIdle) : stMultiNext;
				end
			end
			stMultiNext: begin
				// Next word, Rz forwarded as base, offset field 0x00F
				uopWord = {cond, 3'b010, 4'b1100, isLoad, regRz, mr.nextReg, 12'h00F};
				uopRz.ra1Rz = isLoad;
				uopForward = 1'b1;
				lastOp = lastReg && !writeBack;
				nextState = lastReg ? (writeBack ? stMultiWriteback : stIdle) : stMultiNext;
			end
			stMultiWriteback: begin
				// Rn = Rn +/- count, imm rotated right by 30 gives count times four
				uopWord = {cond, 3'b001, wbOp, 1'b0, heldInstr[19:16], heldInstr[19:16],
					4'hF, 3'b000, totalCount};
			end
			default: begin
				lastOp = 1'b1;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= stIdle;
		else if (xfer)
			state <= nextState;	// Back-pressure freezes the FSM
	end

	// Stalled output stays put
	aHoldStall: assert property (@(posedge clk) disable iff (reset)
		uopValid && !uopReady |=> uopValid && $stable(uopWord) && $stable(uopRz)
			&& $stable(uopForward));

	// Mid-sequence the instruction stays held and the FSM has left idle
	aBusyState: assert property (@(posedge clk) disable iff (reset)
		xfer && !seqDone |=> heldValid && state != stIdle);

endmodule

// File: sim/uopChecks.svh
// Word compare, X or Z on the DUT counts as a mismatch
task automatic checkWord(
	input string name,
	input instrWord_t expected,
	input instrWord_t actual
);
	if (actual !== expected) begin
		$display("ERROR at time %0t: %s expected %h, got %h", $time, name, expected, actual);
		stopWithFailure();
	end
endtask

// Rz steering, shown as {initMux, wa3Rz, ra2Rz, ra1Rz}
task automatic checkRz(
	input string name,
	input rzSel_t expected,
	input rzSel_t actual
);
	if (actual !== expected) begin
		$display("ERROR at time %0t: %s expected %b, got %b", $time, name, expected, actual);
		stopWithFailure();
	end
endtask

// Single flags: forward, valid, ready
task automatic checkBit(
	input string name,
	input logic expected,
	input logic actual
);
	if (actual !== expected) begin
		$display("ERROR at time %0t: %s expected %b, got %b", $time, name, expected, actual);
		stopWithFailure();
	end
endtask

// File: sim/uopExpanderTb.sv
module uopExpanderTb import uopPkg::*; ();

	localparam int vecDepth = 128;	// Lines in the vector memory
	localparam int stallLimit = 200;	// Longest run of stalled cycles
	localparam int readyLimit = 50;	// Cycles to wait for inReady

	logic clk = 1'b0;
	logic reset;
	logic inValid;
	instrWord_t inInstr;
	logic inReady;
	logic uopValid;
	instrWord_t uopWord;
	rzSel_t uopRz;
	logic uopForward;
	logic uopReady;

	logic [39:0] vecMem [0:vecDepth-1];	// Headers followed by their expected ops
	integer seed = 32'h2378;	// Back-pressure generator state
	int recordCount;	// Instructions run so far
	int ptr;	// Header line of the current record

	uopExpander dut (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inInstr(inInstr),
		.inReady(inReady),
		.uopValid(uopValid),
		.uopWord(uopWord),
		.uopRz(uopRz),
		.uopForward(uopForward),
		.uopReady(uopReady)
	);

	always #10 clk = ~clk;	// Period 20

	task automatic stopWithFailure();
		$display("sim failed");
		$fatal(1, "Stopping at the first error");
	endtask

	`include "uopChecks.svh"

	// Offer one instruction once the expander is free
	task automatic sendInstr(input instrWord_t instr);
		int waitCycles;
		waitCycles = 0;
		while (!inReady) begin
			@(negedge clk);
			waitCycles++;
			if (waitCycles > readyLimit) begin
				$display("Timed out waiting for inReady before instruction %h", instr);
				stopWithFailure();
			end
		end
		inValid = 1'b1;
		inInstr = instr;
		@(negedge clk);	// Taken on the rising edge in between
		inValid = 1'b0;
		inInstr = $random(seed);	// Junk that the held copy must ignore
	endtask

	// Walk the expected ops of one record under random back-pressure
	task automatic expectOps(input int base);
		logic [3:0] stallLevel;
		logic [31:0] randVal;
		logic stalled;
		int opCount;
		int opIdx;
		int stallRun;
		instrWord_t expWord;
		rzSel_t expRz;
		logic expFwd;
		stallLevel = vecMem[base][39:36];
		opCount = vecMem[base][35:32];
		opIdx = 0;
		stallRun = 0;
		stalled = 1'b0;
		while (opIdx < opCount) begin
			expWord = vecMem[base + 1 + opIdx][31:0];
			expRz = rzSel_t'(vecMem[base + 1 + opIdx][35:32]);
			expFwd = vecMem[base + 1 + opIdx][36];
			checkBit("uopValid", 1'b1, uopValid);
			checkBit("inReady", 1'b0, inReady);	// Busy until the last op leaves
			if (stalled)
				checkWord("uopWord under stall", expWord, uopWord);	// Same op as before the stall
			else
				checkWord("uopWord", expWord, uopWord);
			checkRz("uopRz", expRz, uopRz);
			checkBit("uopForward", expFwd, uopForward);
			randVal = $random(seed);
			stalled = (randVal[3:0] < stallLevel);	// Stall with odds stallLevel/16
			uopReady = !stalled;
			@(negedge clk);	// Any transfer happened on the edge in between
			if (stalled) begin
				stallRun++;
				if (stallRun > stallLimit) begin
					$display("Back-pressure held the expander for too many cycles");
					stopWithFailure();
				end
			end else begin
				stallRun = 0;
				opIdx++;
			end
		end
		uopReady = 1'b0;
		checkBit("uopValid after sequence", 1'b0, uopValid);	// No extra ops
		checkBit("inReady after sequence", 1'b1, inReady);	// Free one cycle after the last op
	endtask

	initial begin
		reset = 1'b1;
		inValid = 1'b0;
		inInstr = '0;
		uopReady = 1'b0;
		recordCount = 0;
		ptr = 0;
		$readmemh("sim/uopVectors.txt", vecMem);
		repeat (16) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		checkBit("uopValid after reset", 1'b0, uopValid);
		checkBit("inReady after reset", 1'b1, inReady);
		// A header with count 0 closes the list
		while (ptr < vecDepth && !$isunknown(vecMem[ptr]) && vecMem[ptr][35:32] != 4'd0) begin
			sendInstr(vecMem[ptr][31:0]);
			expectOps(ptr);
			ptr = ptr + 1 + vecMem[ptr][35:32];
			recordCount++;
		end
		if (recordCount > 0) begin
			$display("sim passed");
			$finish;
		end else begin
			$display("No vector records were read from sim/uopVectors.txt");
			stopWithFailure();
		end
	end

endmodule

// File: sim/uopVectors.txt
// Header: stall level in 16ths, op count, instruction word (count 0 ends the list)
// Op line: forward bit, rz {initMux,wa3Rz,ra2Rz,ra1Rz}, expected micro-op word
01E0812003
00E0812003
41E5910000
00E5910000
81EA000010
00EA000010
02EB000020
00E24FE004
00EA000020
C21B000005
00124FE004
001A000005
42E0912413
0CE1A0F413
02E091200F
82E8910014
01E5912000
11E59F400F
C4E92D4030
00E50D400C
10E58F500F
10E58FE00F
00E24DDF03
43E8120089
01E5120008
11E59F300F
11E59F700F
83E9A30006
00E5831004
10E58F200F
00E2833F02
0108B50000
0002800000
C2E9360002
01E5161004
00E2466F01
0000000000

// File: tb.f
+incdir+sim
rtl/uopPkg.sv
rtl/multiRegIf.sv
rtl/instrClassifier.sv
rtl/regListWalker.sv
rtl/uopSequencer.sv
rtl/uopExpander.sv
sim/uopExpanderTb.sv
